// ==== src/pcLinkPkg.sv ====
package pcLinkPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Wire format widths

  // One word on the link to the PC
  localparam int unsigned pcWidth = 40;
  // Raw chip word payload
  localparam int unsigned bdWidth = 34;
  // Wall time, split in halves over two heartbeat words
  localparam int unsigned timeWidth = 48;
  localparam int unsigned hbTimeWidth = timeWidth / 2;
  // Spike filter output fields
  localparam int unsigned filterIdxWidth = 10;
  localparam int unsigned filterStateWidth = 27;

  // Derived field widths inside a PC word
  localparam int unsigned bdPadWidth = pcWidth - bdWidth - 1;
  localparam int unsigned filterIdxExtWidth = pcWidth - filterStateWidth - 2;
  localparam int unsigned hbHalfWidth = pcWidth - hbTimeWidth - 2;

  ////////////////////////////////////////////////////////////////////////////
  // Tags and field values

  // Top bit tells chip traffic from FPGA traffic
  localparam logic tagFromBd = 1'b0;
  localparam logic tagFromFpga = 1'b1;
  // Second bit of FPGA words
  localparam logic kindSpike = 1'b0;
  localparam logic kindHeartbeat = 1'b1;
  // Half selector of a heartbeat word
  localparam logic [hbHalfWidth-1:0] hbHalfLow = '0;
  localparam logic [hbHalfWidth-1:0] hbHalfHigh = {{(hbHalfWidth - 1){1'b0}}, 1'b1};

  ////////////////////////////////////////////////////////////////////////////
  // Payload types

  // Word coming up from the chip
  typedef struct packed {
    logic [bdWidth-1:0] payload;
  } bdWord_t;

  // Output of one spike filter
  typedef struct packed {
    logic [filterIdxWidth-1:0] filterIdx;
    logic [filterStateWidth-1:0] filterState;
  } spikeFilterWord_t;

  // Tagged word sent to the PC
  typedef logic [pcWidth-1:0] pcWord_t;

endpackage

// ==== src/heartbeatTimer.sv ====
`timescale 1ns/1ps

module heartbeatTimer #(
  parameter int unsigned timeUnitCycles = 100,
  parameter int unsigned hbPeriodUnits = 1000
) (
  input  logic clk,
  input  logic reset,
  output logic [pcLinkPkg::timeWidth-1:0] timeElapsed,
  output logic hbRequest
);

  // Counter widths, kept at least one bit for degenerate periods
  localparam int unsigned cycleWidth = (timeUnitCycles > 1) ? $clog2(timeUnitCycles) : 1;
  localparam int unsigned periodWidth = (hbPeriodUnits > 1) ? $clog2(hbPeriodUnits) : 1;

  logic [cycleWidth-1:0] cycleCount;
  logic [periodWidth-1:0] periodCount;
  logic unitTick;
  logic periodWrap;

  // Last clock of a time unit
  assign unitTick = (cycleCount == cycleWidth'(timeUnitCycles - 1));
  // Last unit of a heartbeat period
  assign periodWrap = (periodCount == periodWidth'(hbPeriodUnits - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Clock cycles into time units

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      cycleCount <= '0;
    end else if (unitTick) begin
      cycleCount <= '0;
    end else begin
      cycleCount <= cycleCount + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Wall time and heartbeat period

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      timeElapsed <= '0;
      periodCount <= '0;
      hbRequest <= 1'b0;
    end else begin
      // Request lands with the new time value, for one cycle only
      hbRequest <= unitTick && periodWrap;
      if (unitTick) begin
        timeElapsed <= timeElapsed + 1'b1;
        if (periodWrap) begin
          periodCount <= '0;
        end else begin
          periodCount <= periodCount + 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/heartbeatSequencer.sv ====
`timescale 1ns/1ps

module heartbeatSequencer (
  input  logic clk,
  input  logic reset,
  input  logic hbRequest,
  input  logic [pcLinkPkg::timeWidth-1:0] timeElapsed,
  output logic hbValid,
  output pcLinkPkg::pcWord_t hbData,
  input  logic hbAck
);

  typedef enum logic [1:0] {
    stIdle,
    stSendLow,
    stSendHigh
  } hbState_t;

  hbState_t state;
  hbState_t nextState;

  // Snapshot of the time, both halves from one instant
  logic [pcLinkPkg::timeWidth-1:0] latchedTime;
  logic [pcLinkPkg::hbTimeWidth-1:0] timeHalf;
  logic [pcLinkPkg::hbHalfWidth-1:0] halfSel;

  ////////////////////////////////////////////////////////////////////////////
  // State machine

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    unique case (state)
      stIdle: begin
        // Requests while busy are dropped here
        if (hbRequest) begin
          nextState = stSendLow;
        end
      end
      stSendLow: begin
        if (hbAck) begin
          nextState = stSendHigh;
        end
      end
      stSendHigh: begin
        if (hbAck) begin
          nextState = stIdle;
        end
      end
      default: nextState = stIdle;
    endcase
  end

  // Time is captured only when a new heartbeat starts
  always_ff @(posedge clk) begin
    if (state == stIdle && hbRequest) begin
      latchedTime <= timeElapsed;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word build

  always_comb begin
    if (state == stSendHigh) begin
      halfSel = pcLinkPkg::hbHalfHigh;
      timeHalf = latchedTime[pcLinkPkg::timeWidth-1:pcLinkPkg::hbTimeWidth];
    end else begin
      halfSel = pcLinkPkg::hbHalfLow;
      timeHalf = latchedTime[pcLinkPkg::hbTimeWidth-1:0];
    end
  end

  assign hbValid = (state != stIdle);
  // Tag 1,1 then selector then the chosen half
  assign hbData = {pcLinkPkg::tagFromFpga, pcLinkPkg::kindHeartbeat, halfSel, timeHalf};

endmodule

// ==== src/channelQueue.sv ====
`timescale 1ns/1ps

module channelQueue #(
  parameter type payload_t = logic [7:0],
  parameter int unsigned depth = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic inValid,
  input  payload_t inData,
  output logic inAck,
  output logic outValid,
  output payload_t outData,
  input  logic outAck
);

  // Pointer and occupancy widths
  localparam int unsigned ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned countWidth = $clog2(depth + 1);

  // Payload storage
  payload_t mem [depth];

  logic [ptrWidth-1:0] writePtr;
  logic [ptrWidth-1:0] readPtr;
  logic [countWidth-1:0] count;
  logic doWrite;
  logic doRead;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake

  // Accept while out of reset and not full
  assign inAck = !reset && (count != countWidth'(depth));
  // Head entry is visible one cycle after its write
  assign outValid = (count != '0);
  assign outData = mem[readPtr];

  assign doWrite = inValid && inAck;
  assign doRead = outValid && outAck;

  ////////////////////////////////////////////////////////////////////////////
  // Circular buffer

  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[writePtr] <= inData;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      writePtr <= '0;
      readPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        // Wrap at depth, which need not be a power of two
        writePtr <= (writePtr == ptrWidth'(depth - 1)) ? '0 : writePtr + 1'b1;
      end
      if (doRead) begin
        readPtr <= (readPtr == ptrWidth'(depth - 1)) ? '0 : readPtr + 1'b1;
      end
      // Simultaneous write and read leaves the count alone
      if (doWrite && !doRead) begin
        count <= count + 1'b1;
      end else if (doRead && !doWrite) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== src/streamMerge.sv ====
`timescale 1ns/1ps

module streamMerge (
  input  logic clk,
  input  logic reset,
  input  logic aValid,
  input  pcLinkPkg::pcWord_t aData,
  output logic aAck,
  input  logic bValid,
  input  pcLinkPkg::pcWord_t bData,
  output logic bAck,
  output logic outValid,
  output pcLinkPkg::pcWord_t outData,
  input  logic outAck
);

  // Round robin pointer, high when b wins the next tie
  logic preferB;
  logic grantA;
  logic grantB;
  // Output register is free now or drains this cycle
  logic canAccept;
  logic takeA;
  logic takeB;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration

  assign canAccept = !outValid || outAck;

  // Single valid input wins outright, ties go by the pointer
  assign grantA = aValid && (!bValid || !preferB);
  assign grantB = bValid && (!aValid || preferB);

  assign takeA = canAccept && grantA;
  assign takeB = canAccept && grantB;

  assign aAck = takeA;
  assign bAck = takeB;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      preferB <= 1'b0;
    end else if (takeA) begin
      // A served, B gets the next tie
      preferB <= 1'b1;
    end else if (takeB) begin
      preferB <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register

  // Valid flag of the one-entry stage
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      outValid <= 1'b0;
    end else if (takeA || takeB) begin
      // Refill, possibly in the same cycle as the drain
      outValid <= 1'b1;
    end else if (outAck) begin
      outValid <= 1'b0;
    end
  end

  // Payload follows the grant
  always_ff @(posedge clk) begin
    if (takeA) begin
      outData <= aData;
    end else if (takeB) begin
      outData <= bData;
    end
  end

endmodule

// ==== src/pcPacker.sv ====
`timescale 1ns/1ps

module pcPacker #(
  parameter int unsigned timeUnitCycles = 100,
  parameter int unsigned hbPeriodUnits = 1000,
  parameter int unsigned queueDepth = 8
) (
  input  logic clk,
  input  logic reset,
  // Raw chip words
  input  logic bdValid,
  input  pcLinkPkg::bdWord_t bdData,
  output logic bdAck,
  // Spike filter words
  input  logic sfValid,
  input  pcLinkPkg::spikeFilterWord_t sfData,
  output logic sfAck,
  // Merged stream to the PC
  output logic pcValid,
  output pcLinkPkg::pcWord_t pcData,
  input  logic pcAck
);

  // Wall time and heartbeat trigger
  logic [pcLinkPkg::timeWidth-1:0] timeElapsed;
  logic hbRequest;

  // Heartbeat channel
  logic hbValid;
  pcLinkPkg::pcWord_t hbData;
  logic hbAck;

  // Queue outputs, still in source format
  logic bdQueueValid;
  pcLinkPkg::bdWord_t bdQueueData;
  logic bdQueueAck;
  logic sfQueueValid;
  pcLinkPkg::spikeFilterWord_t sfQueueData;
  logic sfQueueAck;

  // Framed words
  pcLinkPkg::pcWord_t bdFramed;
  pcLinkPkg::pcWord_t sfFramed;
  logic [pcLinkPkg::filterIdxExtWidth-1:0] filterIdxExt;

  // Inner merge output, filter plus heartbeat
  logic fpgaValid;
  pcLinkPkg::pcWord_t fpgaData;
  logic fpgaAck;

  ////////////////////////////////////////////////////////////////////////////
  // Heartbeat source

  heartbeatTimer #(
    .timeUnitCycles(timeUnitCycles),
    .hbPeriodUnits (hbPeriodUnits)
  ) u_heartbeatTimer (
    .clk        (clk),
    .reset      (reset),
    .timeElapsed(timeElapsed),
    .hbRequest  (hbRequest)
  );

  heartbeatSequencer u_heartbeatSequencer (
    .clk        (clk),
    .reset      (reset),
    .hbRequest  (hbRequest),
    .timeElapsed(timeElapsed),
    .hbValid    (hbValid),
    .hbData     (hbData),
    .hbAck      (hbAck)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Ingress queues

  channelQueue #(
    .payload_t(pcLinkPkg::bdWord_t),
    .depth    (queueDepth)
  ) u_bdQueue (
    .clk     (clk),
    .reset   (reset),
    .inValid (bdValid),
    .inData  (bdData),
    .inAck   (bdAck),
    .outValid(bdQueueValid),
    .outData (bdQueueData),
    .outAck  (bdQueueAck)
  );

  channelQueue #(
    .payload_t(pcLinkPkg::spikeFilterWord_t),
    .depth    (queueDepth)
  ) u_sfQueue (
    .clk     (clk),
    .reset   (reset),
    .inValid (sfValid),
    .inData  (sfData),
    .inAck   (sfAck),
    .outValid(sfQueueValid),
    .outData (sfQueueData),
    .outAck  (sfQueueAck)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Framing

  // Tag 0, zero pad, chip payload
  assign bdFramed = {pcLinkPkg::tagFromBd, {pcLinkPkg::bdPadWidth{1'b0}}, bdQueueData.payload};

  // Index widened to the 11-bit field
  assign filterIdxExt = {{(pcLinkPkg::filterIdxExtWidth - pcLinkPkg::filterIdxWidth){1'b0}},
                         sfQueueData.filterIdx};
  // Tags 1,0 then index and state
  assign sfFramed = {pcLinkPkg::tagFromFpga, pcLinkPkg::kindSpike, filterIdxExt,
                     sfQueueData.filterState};

  ////////////////////////////////////////////////////////////////////////////
  // Merge tree

  streamMerge u_fpgaMerge (
    .clk     (clk),
    .reset   (reset),
    .aValid  (sfQueueValid),
    .aData   (sfFramed),
    .aAck    (sfQueueAck),
    .bValid  (hbValid),
    .bData   (hbData),
    .bAck    (hbAck),
    .outValid(fpgaValid),
    .outData (fpgaData),
    .outAck  (fpgaAck)
  );

  // Root joins chip traffic with FPGA traffic
  streamMerge u_rootMerge (
    .clk     (clk),
    .reset   (reset),
    .aValid  (bdQueueValid),
    .aData   (bdFramed),
    .aAck    (bdQueueAck),
    .bValid  (fpgaValid),
    .bData   (fpgaData),
    .bAck    (fpgaAck),
    .outValid(pcValid),
    .outData (pcData),
    .outAck  (pcAck)
  );

endmodule

// ==== test/pcPacker_assertions.sv ====
`timescale 1ns/1ps

module pcPacker_assertions (
  input logic clk,
  input logic reset,
  input logic pcValid,
  input pcLinkPkg::pcWord_t pcData,
  input logic pcAck,
  input logic hbValid,
  input pcLinkPkg::pcWord_t hbData,
  input logic hbAck
);

  // Failures seen so far, read by the testbench at the end
  int assertFailures = 0;

  // Which heartbeat half the sequencer shows right now
  logic hbLowShown;
  logic hbHighShown;

  assign hbLowShown = hbValid && (hbData[37:24] == 14'd0);
  assign hbHighShown = hbValid && (hbData[37:24] == 14'd1);

  ////////////////////////////////////////////////////////////////////////////
  // Output channel

  // Stalled word holds until the PC takes it
  pcHoldsWhileStalled: assert property (@(posedge clk) disable iff (reset)
    pcValid && !pcAck |=> pcValid && $stable(pcData))
  else begin
    assertFailures++;
    $error("pcData or pcValid changed while the output word was stalled");
  end

  // Nothing goes out while reset is high
  pcQuietInReset: assert property (@(posedge clk) reset |-> !pcValid)
  else begin
    assertFailures++;
    $error("pcValid high during reset");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Heartbeat sequencer

  // High half only ever starts right after the low half was taken
  hbHighAfterLow: assert property (@(posedge clk) disable iff (reset)
    $rose(hbHighShown) |-> $past(hbLowShown && hbAck))
  else begin
    assertFailures++;
    $error("heartbeat high word shown without an acked low word before it");
  end

endmodule

bind pcPacker pcPacker_assertions u_pcPackerAssertions (
  .clk    (clk),
  .reset  (reset),
  .pcValid(pcValid),
  .pcData (pcData),
  .pcAck  (pcAck),
  .hbValid(hbValid),
  .hbData (hbData),
  .hbAck  (hbAck)
);

// ==== test/pcPackerTb.sv ====
`timescale 1ns/1ps

module pcPackerTb;

  // Short periods so heartbeats come every 64 clocks
  localparam int unsigned timeUnitCycles = 4;
  localparam int unsigned hbPeriodUnits = 16;
  localparam int unsigned queueDepth = 4;

  // Selectors for the wait loop
  localparam int condDrained = 0;
  localparam int condAcksLow = 1;
  localparam int condHeartbeats = 2;

  logic clk;
  logic reset;
  logic bdValid;
  pcLinkPkg::bdWord_t bdData;
  logic bdAck;
  logic sfValid;
  pcLinkPkg::spikeFilterWord_t sfData;
  logic sfAck;
  logic pcValid;
  pcLinkPkg::pcWord_t pcData;
  logic pcAck;

  integer seed;
  int errorCount;
  int checkCount;
  int testsRun;
  bit aborted;

  // Words still to send and idle cycles before the next one
  int bdLeft;
  int sfLeft;
  int bdGap;
  int sfGap;
  int bdSent;
  int sfSent;
  // Ack values seen at the falling edge decide the next rising edge
  logic bdAckSeen;
  logic sfAckSeen;
  bit sinkRandom;

  // Reference model
  pcLinkPkg::pcWord_t bdExp[$];
  pcLinkPkg::pcWord_t sfExp[$];
  int bdRecv;
  int sfRecv;
  int hbSeen;
  bit lowPending;
  logic [23:0] lowHalf;
  logic [47:0] lastHbTime;

  pcPacker #(
    .timeUnitCycles(timeUnitCycles),
    .hbPeriodUnits (hbPeriodUnits),
    .queueDepth    (queueDepth)
  ) u_pcPacker (
    .clk    (clk),
    .reset  (reset),
    .bdValid(bdValid),
    .bdData (bdData),
    .bdAck  (bdAck),
    .sfValid(sfValid),
    .sfData (sfData),
    .sfAck  (sfAck),
    .pcValid(pcValid),
    .pcData (pcData),
    .pcAck  (pcAck)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Framing rules and error reporting

  // Tag 0, five zero bits, payload
  function automatic pcLinkPkg::pcWord_t frameBd(input logic [33:0] payload);
    return {1'b0, 5'b00000, payload};
  endfunction

  // Tags 1,0 then the index widened to 11 bits, then the state
  function automatic pcLinkPkg::pcWord_t frameFilter(input logic [9:0] idx,
                                                     input logic [26:0] state);
    return {2'b10, 1'b0, idx, state};
  endfunction

  // One of the three legal tag patterns
  function automatic bit legalTag(input pcLinkPkg::pcWord_t w);
    if (w[39] == 1'b0)
      return w[38:34] == 5'b00000;
    if (w[38] == 1'b0)
      return w[37] == 1'b0;
    return w[37:24] <= 14'd1;
  endfunction

  task automatic reportMismatch(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    errorCount++;
  endtask

  task automatic finishTest(input string name, input int startErrors);
    testsRun++;
    $display("Test %s finished, %0d errors", name, errorCount - startErrors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard

  task automatic checkWord(input pcLinkPkg::pcWord_t w);
    pcLinkPkg::pcWord_t exp;
    logic [47:0] hbTime;
    checkCount++;
    if (!legalTag(w))
      reportMismatch($sformatf("illegal tag pattern in word %h", w));
    if (w[39] == 1'b0) begin
      bdRecv++;
      if (bdExp.size() == 0) begin
        reportMismatch($sformatf("BD word %h with none outstanding", w));
      end else begin
        exp = bdExp.pop_front();
        if (w !== exp)
          reportMismatch($sformatf("BD word got %h expected %h", w, exp));
      end
    end else if (w[38] == 1'b0) begin
      sfRecv++;
      if (sfExp.size() == 0) begin
        reportMismatch($sformatf("filter word %h with none outstanding", w));
      end else begin
        exp = sfExp.pop_front();
        if (w !== exp)
          reportMismatch($sformatf("filter word got %h expected %h", w, exp));
      end
    end else if (w[37:24] == 14'd0) begin
      // Low half opens a heartbeat
      if (lowPending)
        reportMismatch("second low heartbeat word before a high word");
      lowPending = 1'b1;
      lowHalf = w[23:0];
    end else if (w[37:24] == 14'd1) begin
      if (!lowPending) begin
        reportMismatch("high heartbeat word without a low word");
      end else begin
        hbTime = {w[23:0], lowHalf};
        if (hbTime == 0 || hbTime % hbPeriodUnits != 0)
          reportMismatch($sformatf("heartbeat time %0d not a period multiple", hbTime));
        if (hbTime <= lastHbTime)
          reportMismatch($sformatf("heartbeat time %0d after %0d", hbTime, lastHbTime));
        lastHbTime = hbTime;
        hbSeen++;
      end
      lowPending = 1'b0;
    end
  endtask

  task automatic checkCounts();
    if (bdRecv != bdSent)
      reportMismatch($sformatf("BD words received %0d, sent %0d", bdRecv, bdSent));
    if (sfRecv != sfSent)
      reportMismatch($sformatf("filter words received %0d, sent %0d", sfRecv, sfSent));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sources and sink, all on the falling edge

  task automatic driveCycle();
    logic [63:0] wide;
    // BD word taken on the last rising edge
    if (bdValid && bdAckSeen) begin
      bdExp.push_back(frameBd(bdData.payload));
      bdSent++;
      bdLeft--;
      bdValid = 1'b0;
      bdGap = {$random(seed)} % 4;
    end
    if (!bdValid && bdLeft > 0) begin
      if (bdGap == 0) begin
        wide = {$random(seed), $random(seed)};
        bdData.payload = wide[33:0];
        bdValid = 1'b1;
      end else begin
        bdGap--;
      end
    end
    // Queue ack does not depend on valid and holds until the rising edge
    bdAckSeen = bdAck;
    if (sfValid && sfAckSeen) begin
      sfExp.push_back(frameFilter(sfData.filterIdx, sfData.filterState));
      sfSent++;
      sfLeft--;
      sfValid = 1'b0;
      sfGap = {$random(seed)} % 4;
    end
    if (!sfValid && sfLeft > 0) begin
      if (sfGap == 0) begin
        wide = {$random(seed), $random(seed)};
        sfData.filterIdx = wide[36:27];
        sfData.filterState = wide[26:0];
        sfValid = 1'b1;
      end else begin
        sfGap--;
      end
    end
    sfAckSeen = sfAck;
    // Sink acks about three cycles in four
    pcAck = sinkRandom ? (({$random(seed)} % 4) != 0) : 1'b0;
    if (pcValid && pcAck)
      checkWord(pcData);
  endtask

  initial begin
    forever begin
      @(negedge clk);
      driveCycle();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Waits and tests

  function automatic bit conditionMet(input int which);
    case (which)
      condDrained: return bdLeft == 0 && sfLeft == 0 && !bdValid && !sfValid &&
                          bdExp.size() == 0 && sfExp.size() == 0;
      condAcksLow: return !bdAckSeen && !sfAckSeen;
      default: return hbSeen >= 3;
    endcase
  endfunction

  task automatic waitFor(input int which, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (!conditionMet(which) && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!conditionMet(which)) begin
      $display("Timeout at %0t: gave up waiting for %s after %0d cycles", $time, what, limit);
      errorCount++;
      aborted = 1'b1;
    end
  endtask

  task automatic checkReset();
    int startErrors;
    int i;
    startErrors = errorCount;
    for (i = 0; i < 16; i++) begin
      @(negedge clk);
      if (pcValid !== 1'b0)
        reportMismatch("pcValid high during reset");
      if (bdAck !== 1'b0 || sfAck !== 1'b0)
        reportMismatch("ingress ack high during reset");
    end
    reset = 1'b0;
    // First cycle out of reset
    @(negedge clk);
    if (pcValid !== 1'b0)
      reportMismatch("pcValid high in the first cycle after reset");
    @(posedge clk);
    finishTest("reset", startErrors);
  endtask

  task automatic randomTraffic();
    int startErrors;
    startErrors = errorCount;
    sinkRandom = 1'b1;
    bdLeft = 60;
    sfLeft = 60;
    waitFor(condDrained, 4000, "random traffic to drain");
    checkCounts();
    finishTest("randomTraffic", startErrors);
  endtask

  task automatic backPressure();
    int startErrors;
    startErrors = errorCount;
    sinkRandom = 1'b0;
    bdLeft = 24;
    sfLeft = 24;
    waitFor(condAcksLow, 500, "bdAck and sfAck to drop");
    if (!aborted) begin
      // Stall across a few heartbeat periods
      repeat (200) @(posedge clk);
      if (bdAckSeen || sfAckSeen)
        reportMismatch("ingress ack came back while the sink stalled");
      sinkRandom = 1'b1;
      waitFor(condDrained, 4000, "traffic to drain after the stall");
      checkCounts();
    end
    finishTest("backPressure", startErrors);
  endtask

  task automatic heartbeats();
    int startErrors;
    startErrors = errorCount;
    sinkRandom = 1'b1;
    waitFor(condHeartbeats, 2000, "three heartbeats");
    finishTest("heartbeats", startErrors);
  endtask

  initial begin
    seed = 37689;
    reset = 1'b1;
    bdValid = 1'b0;
    bdData = '0;
    sfValid = 1'b0;
    sfData = '0;
    pcAck = 1'b0;
    errorCount = 0;
    checkCount = 0;
    testsRun = 0;
    aborted = 1'b0;
    sinkRandom = 1'b0;
    lowPending = 1'b0;
    lastHbTime = '0;
    checkReset();
    if (!aborted)
      randomTraffic();
    if (!aborted)
      backPressure();
    if (!aborted)
      heartbeats();
    errorCount += u_pcPacker.u_pcPackerAssertions.assertFailures;
    $display("Done: %0d tests, %0d words checked, %0d heartbeats, %0d errors",
             testsRun, checkCount, hbSeen, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/pcLinkPkg.sv
src/heartbeatTimer.sv
src/heartbeatSequencer.sv
src/channelQueue.sv
src/streamMerge.sv
src/pcPacker.sv
test/pcPacker_assertions.sv
test/pcPackerTb.sv
